// ==== sim.f ====
+incdir+include
hdl/cache_pkg.sv
hdl/line_xfer_if.sv
hdl/proc_port.sv
hdl/mem_port.sv
hdl/cache_store.sv
hdl/cache_ctrl.sv
hdl/cache.sv
bench/tb_clock.sv
bench/mem_model.sv
bench/tb_cache.sv

// ==== Makefile ====
# Verilator flow for the two-way cache and its testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module cache

# the run passes only if the testbench prints the pass line
sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_cache -o tb_cache
	@out="$$(./obj_dir/tb_cache)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== bench/tb_cache.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_cache import cache_pkg::*; ();

	localparam int W       = `BUS_DATA_WIDTH;
	localparam int TIMEOUT = 2000;   // cycles allowed per wait

	logic        clk;
	logic        reset;
	logic        p_bus_reqcyc;
	logic        p_bus_reqack;
	bus_word_u   p_bus_req;
	bus_tag_t    p_bus_reqtag;
	logic        p_bus_respcyc;
	logic        p_bus_respack;
	logic [W-1:0] p_bus_resp;
	bus_tag_t    p_bus_resptag;
	logic        m_bus_reqcyc;
	logic        m_bus_reqack;
	logic [W-1:0] m_bus_req;
	bus_tag_t    m_bus_reqtag;
	logic        m_bus_respcyc;
	logic        m_bus_respack;
	logic [W-1:0] m_bus_resp;
	bus_tag_t    m_bus_resptag;
	int          read_count;
	int          write_count;
	logic [63:0] last_wr_addr;
	line_t       last_wr_line;

	int          errors;
	int          checks;
	bit          stalled;        // a handshake timed out, remaining steps are skipped
	logic [31:0] lfsr_state;
	line_t       sb [logic [63:0]];   // expected line contents by line address

	tb_clock clock_inst (.*);
	cache cache_inst (.*);
	mem_model mem_inst (.*);

	// galois lfsr, one step per bit taken
	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] v;
		logic lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb)
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			v = {v[62:0], lsb};
		end
		return v;
	endfunction

	function automatic line_t random_line();
		line_t l;
		for (int k = 0; k < `LINE_BEATS; k++)
			l[k*W +: W] = rand_bits(W);
		return l;
	endfunction

	// what memory holds at a byte address nobody has written
	function automatic logic [63:0] pattern_word(logic [63:0] line_base, int k);
		logic [63:0] a;
		a = line_base + 64'(k * 8);
		return a ^ {a[31:0], a[63:32]} ^ 64'hc3a5_0f1e_7d29_b486;
	endfunction

	function automatic line_t expected_line(logic [63:0] a);
		line_t l;
		if (sb.exists(a))
			return sb[a];
		for (int k = 0; k < `LINE_BEATS; k++)
			l[k*W +: W] = pattern_word(a, k);
		return l;
	endfunction

	function automatic bus_word_u line_addr(line_tag_t tag, int set);
		bus_word_u a;
		a.addr.tag    = tag;
		a.addr.index  = `INDEX_BITS'(set);
		a.addr.offset = '0;   // whole lines only
		return a;
	endfunction

	task automatic check_word(bus_word_u got, bus_word_u exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s got %h expected %h", $time, what, got.data,
				exp.data);
		end
	endtask

	task automatic check_tag(bus_tag_t got, bus_tag_t exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s tag %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(int got, int exp, string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("** Error at %0d ns: %s is %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// one request word, held through its ack cycle, with an idle cycle in front
	task automatic send_word(bus_word_u word, bus_tag_t tag);
		int n;
		bit acked;
		if (stalled)
			return;
		@(negedge clk);
		p_bus_req    = word;
		p_bus_reqtag = tag;
		p_bus_reqcyc = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!p_bus_reqack && n < TIMEOUT);
		acked = p_bus_reqack;
		if (acked)
			@(negedge clk);   // ack sampled at the rising edge in between
		p_bus_reqcyc = 1'b0;
		if (!acked) begin
			stalled = 1'b1;
			$display("timeout: request word %h was never acknowledged", word.data);
		end
	endtask

	task automatic proc_read(bus_word_u addr, logic [11:0] id);
		bus_tag_t tag;
		line_t exp;
		int n;
		tag = bus_tag_t'(id);
		tag[`SYSBUS_WRITE_BIT] = ~`SYSBUS_WRITE;
		exp = expected_line(addr.data);
		send_word(addr, tag);
		for (int k = 0; k < `LINE_BEATS && !stalled; k++) begin
			n = 0;
			while (!p_bus_respcyc && n < TIMEOUT) begin
				@(negedge clk);
				n++;
			end
			if (!p_bus_respcyc) begin
				stalled = 1'b1;
				$display("timeout: beat %0d of the read at %h never arrived", k, addr.data);
			end else begin
				check_word(p_bus_resp, exp[k*W +: W], $sformatf("read %h beat %0d", addr.data, k));
				check_tag(p_bus_resptag, tag, $sformatf("read %h beat %0d", addr.data, k));
				p_bus_respack = 1'b1;   // take the beat at the next edge
				@(negedge clk);
				p_bus_respack = 1'b0;
			end
		end
	endtask

	// address word then eight data words, no response comes back
	task automatic proc_write(bus_word_u addr, logic [11:0] id, line_t data);
		bus_tag_t tag;
		bus_word_u w;
		tag = bus_tag_t'(id);
		tag[`SYSBUS_WRITE_BIT] = `SYSBUS_WRITE;
		send_word(addr, tag);
		for (int k = 0; k < `LINE_BEATS; k++) begin
			w.data = data[k*W +: W];
			send_word(w, tag);
		end
		sb[addr.data] = data;
	endtask

	task automatic finish_test(string name, int errors_before);
		if (stalled)
			$display("%s: aborted", name);
		else if (errors == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errors_before);
	endtask

	task automatic read_miss_test();
		int e0;
		int r0;
		int w0;
		e0 = errors;
		r0 = read_count;
		w0 = write_count;
		proc_read(line_addr(54'h1234, 1), 12'h011);
		check_count(read_count, r0 + 1, "memory reads after miss");
		check_count(write_count, w0, "memory writes after miss");
		finish_test("read miss", e0);
	endtask

	task automatic read_hit_test();
		int e0;
		int r0;
		int w0;
		e0 = errors;
		r0 = read_count;
		w0 = write_count;
		proc_read(line_addr(54'h1234, 1), 12'h022);   // line filled by the miss
		check_count(read_count, r0, "memory reads after hit");
		check_count(write_count, w0, "memory writes after hit");
		finish_test("read hit", e0);
	endtask

	task automatic write_read_test();
		int e0;
		int r0;
		int w0;
		bus_word_u a;
		e0 = errors;
		r0 = read_count;
		w0 = write_count;
		a  = line_addr(54'h0777, 2);
		proc_write(a, 12'h033, random_line());
		proc_read(a, 12'h034);
		check_count(read_count, r0, "memory reads after write and read");
		check_count(write_count, w0, "memory writes with room in set");
		finish_test("write then read", e0);
	endtask

	task automatic eviction_test();
		int e0;
		int r0;
		int w0;
		bus_word_u a1;
		bus_word_u a2;
		bus_word_u a3;
		line_t d1;
		e0 = errors;
		a1 = line_addr(54'h00a1, 5);
		a2 = line_addr(54'h00a2, 5);
		a3 = line_addr(54'h00a3, 5);
		d1 = random_line();
		w0 = write_count;
		proc_write(a1, 12'h401, d1);
		proc_write(a2, 12'h402, random_line());
		proc_write(a3, 12'h403, random_line());   // least recent a1 goes out
		proc_read(a3, 12'h404);   // hit, accepted once the write-back is over
		check_count(write_count, w0 + 1, "memory writes after eviction");
		check_word(last_wr_addr, a1, "write-back address");
		for (int k = 0; k < `LINE_BEATS; k++)
			check_word(last_wr_line[k*W +: W], d1[k*W +: W], $sformatf("write-back beat %0d", k));
		r0 = read_count;
		proc_read(a1, 12'h405);   // comes back through memory
		check_count(read_count, r0 + 1, "memory reads for evicted line");
		finish_test("dirty eviction", e0);
	endtask

	// four tags over four sets, enough to force evictions
	task automatic random_mix_test();
		int e0;
		bus_word_u a;
		e0 = errors;
		for (int i = 0; i < 40; i++) begin
			a = line_addr(line_tag_t'(54'h100 + rand_bits(2)), 8 + int'(rand_bits(2)));
			if (rand_bits(1) == 64'd1)
				proc_write(a, 12'(rand_bits(12)), random_line());
			else
				proc_read(a, 12'(rand_bits(12)));
		end
		finish_test("random mix", e0);
	endtask

	initial begin
		p_bus_reqcyc  = 1'b0;
		p_bus_req     = '0;
		p_bus_reqtag  = '0;
		p_bus_respack = 1'b0;
		lfsr_state    = 32'h0e38_9e7c;
		errors        = 0;
		checks        = 0;
		stalled       = 1'b0;
		@(negedge clk);
		for (int n = 0; n < TIMEOUT && reset; n++)
			@(negedge clk);
		if (reset) begin
			stalled = 1'b1;
			$display("timeout: reset was never released");
		end
		read_miss_test();
		read_hit_test();
		write_read_test();
		eviction_test();
		random_mix_test();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0 && !stalled)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== bench/mem_model.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

// behavioural memory, answers fills and takes write-backs on the memory bus
module mem_model import cache_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       m_bus_reqcyc,
	output logic                       m_bus_reqack,
	input  logic [`BUS_DATA_WIDTH-1:0] m_bus_req,
	input  bus_tag_t                   m_bus_reqtag,
	output logic                       m_bus_respcyc,
	input  logic                       m_bus_respack,
	output logic [`BUS_DATA_WIDTH-1:0] m_bus_resp,
	output bus_tag_t                   m_bus_resptag,
	output int                         read_count,
	output int                         write_count,
	output logic [63:0]                last_wr_addr,   // most recent write-back line
	output line_t                      last_wr_line
);

	logic [63:0] words [logic [63:0]];   // written words by byte address
	logic        ack_q  = 1'b0;
	logic        cyc_q  = 1'b0;
	logic [63:0] resp_q = '0;
	bus_tag_t    rtag_q = '0;
	logic [63:0] wr_base;
	logic [63:0] rd_base;
	bus_tag_t    rd_tag;
	int          wr_left = 0;   // data words still expected for a write
	int          rd_left = 0;   // beats still to send for a fill
	int          rd_beat = 0;
	logic        taken   = 1'b0;

	assign m_bus_reqack  = ack_q;
	assign m_bus_respcyc = cyc_q;
	assign m_bus_resp    = resp_q;
	assign m_bus_resptag = rtag_q;

	// unwritten memory, every word mixes its full byte address
	function automatic logic [63:0] read_word(logic [63:0] a);
		if (words.exists(a))
			return words[a];
		return a ^ {a[31:0], a[63:32]} ^ 64'hc3a5_0f1e_7d29_b486;
	endfunction

	always @(posedge clk) taken <= m_bus_respcyc && m_bus_respack;   // beat consumed here

	always @(negedge clk) begin
		if (reset) begin
			ack_q       <= 1'b0;
			cyc_q       <= 1'b0;
			wr_left     <= 0;
			rd_left     <= 0;
			read_count  <= 0;
			write_count <= 0;
		end else begin
			ack_q <= 1'b0;
			if (m_bus_reqcyc && !ack_q) begin
				ack_q <= 1'b1;   // one cycle ack per word
				if (wr_left > 0) begin
					words[wr_base + 64'((`LINE_BEATS - wr_left) * 8)] = m_bus_req;
					last_wr_line[(`LINE_BEATS - wr_left)*`BUS_DATA_WIDTH +: `BUS_DATA_WIDTH]
						<= m_bus_req;
					wr_left <= wr_left - 1;
				end else if (m_bus_reqtag[`SYSBUS_WRITE_BIT] == `SYSBUS_WRITE) begin
					wr_base      <= m_bus_req;   // address word of a write-back
					last_wr_addr <= m_bus_req;
					wr_left      <= `LINE_BEATS;
					write_count  <= write_count + 1;
				end else begin
					rd_base    <= m_bus_req;
					rd_tag     <= m_bus_reqtag;
					rd_left    <= `LINE_BEATS;
					rd_beat    <= 0;
					read_count <= read_count + 1;
				end
			end
			if (taken) begin
				cyc_q   <= 1'b0;   // gap before the next beat
				rd_beat <= rd_beat + 1;
				rd_left <= rd_left - 1;
			end else if (rd_left > 0 && !cyc_q) begin
				cyc_q  <= 1'b1;
				resp_q <= read_word(rd_base + 64'(rd_beat * 8));
				rtag_q <= rd_tag;   // echo the request tag
			end
		end
	end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;   // 4 ns period
	end

	// reset held over five rising edges, dropped on a falling edge
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== hdl/cache.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module cache import cache_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,

	// processor bus
	input  logic                       p_bus_reqcyc,
	output logic                       p_bus_reqack,
	input  logic [`BUS_DATA_WIDTH-1:0] p_bus_req,
	input  logic [`BUS_TAG_WIDTH-1:0]  p_bus_reqtag,
	output logic                       p_bus_respcyc,
	input  logic                       p_bus_respack,
	output logic [`BUS_DATA_WIDTH-1:0] p_bus_resp,
	output logic [`BUS_TAG_WIDTH-1:0]  p_bus_resptag,

	// memory bus
	output logic                       m_bus_reqcyc,
	input  logic                       m_bus_reqack,
	output logic [`BUS_DATA_WIDTH-1:0] m_bus_req,
	output logic [`BUS_TAG_WIDTH-1:0]  m_bus_reqtag,
	input  logic                       m_bus_respcyc,
	output logic                       m_bus_respack,
	input  logic [`BUS_DATA_WIDTH-1:0] m_bus_resp,
	input  logic [`BUS_TAG_WIDTH-1:0]  m_bus_resptag
);

	// ctrl to store lookup and update
	logic [`INDEX_BITS-1:0] index;
	line_tag_t              look_tag;
	logic                   hit;
	logic [WAY_BITS-1:0]    hit_way;
	logic [WAY_BITS-1:0]    victim_way;
	logic                   victim_dirty;
	line_tag_t              victim_tag;
	line_t                  rd_line;
	logic                   upd_en;
	logic [WAY_BITS-1:0]    upd_way;
	logic                   upd_dirty;
	line_t                  upd_line;
	logic                   touch_en;

	line_xfer_if proc_xfer ();   // proc_port raises requests, ctrl orders responses
	line_xfer_if mem_xfer ();    // ctrl orders fills and write-backs

	proc_port proc_port_inst (
		.clk, .reset,
		.p_bus_reqcyc, .p_bus_req, .p_bus_reqtag, .p_bus_respack,
		.p_bus_reqack, .p_bus_respcyc, .p_bus_resp, .p_bus_resptag,
		.xfer(proc_xfer.port)
	);

	mem_port mem_port_inst (
		.clk, .reset,
		.m_bus_reqack, .m_bus_respcyc, .m_bus_resp, .m_bus_resptag,
		.m_bus_reqcyc, .m_bus_req, .m_bus_reqtag, .m_bus_respack,
		.xfer(mem_xfer.port)
	);

	cache_store store_inst (
		.clk, .reset,
		.index, .look_tag, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.rd_line, .upd_en, .upd_way, .upd_dirty, .upd_line, .touch_en
	);

	cache_ctrl ctrl_inst (
		.clk, .reset,
		.proc(proc_xfer.ctl), .mem(mem_xfer.ctl),
		.index, .look_tag, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.rd_line, .upd_en, .upd_way, .upd_dirty, .upd_line, .touch_en
	);

endmodule

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl import cache_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	line_xfer_if.ctl                proc,
	line_xfer_if.ctl                mem,
	output logic [`INDEX_BITS-1:0]  index,
	output line_tag_t               look_tag,
	input  logic                    hit,
	input  logic [WAY_BITS-1:0]     hit_way,
	input  logic [WAY_BITS-1:0]     victim_way,
	input  logic                    victim_dirty,
	input  line_tag_t               victim_tag,
	input  line_t                   rd_line,
	output logic                    upd_en,
	output logic [WAY_BITS-1:0]     upd_way,
	output logic                    upd_dirty,
	output line_t                   upd_line,
	output logic                    touch_en
);

	typedef enum logic [2:0] {C_IDLE, C_LOOK, C_WB, C_FILL, C_UPD, C_RESP} cstate_t;

	cstate_t             state;
	logic [WAY_BITS-1:0] way_q;        // way being replaced or overwritten
	line_t               line_q;       // victim, write data, fill or hit line
	logic                mem_start_q;
	logic                mem_write_q;  // 1 for write-back, 0 for fill
	bus_word_u           mem_addr_q;
	bus_word_u           fill_addr;

	always_comb begin
		fill_addr = proc.addr;
		fill_addr.addr.offset = '0;   // line aligned
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= C_IDLE;
			mem_start_q <= 1'b0;
			mem_write_q <= 1'b0;
		end else begin
			mem_start_q <= 1'b0;
			case (state)
				C_IDLE: if (proc.done) state <= C_LOOK;
				C_LOOK: begin
					if (hit) begin
						state <= proc.write ? C_UPD : C_RESP;
					end else if (victim_dirty) begin
						state       <= C_WB;
						mem_start_q <= 1'b1;
						mem_write_q <= 1'b1;
					end else if (proc.write) begin
						state <= C_UPD;   // write miss allocates without reading
					end else begin
						state       <= C_FILL;
						mem_start_q <= 1'b1;
						mem_write_q <= 1'b0;
					end
				end
				C_WB: begin
					if (mem.done) begin
						if (proc.write) begin
							state <= C_UPD;
						end else begin
							state       <= C_FILL;
							mem_start_q <= 1'b1;
							mem_write_q <= 1'b0;
						end
					end
				end
				C_FILL: if (mem.done) state <= C_UPD;
				C_UPD: state <= C_RESP;
				C_RESP: state <= C_IDLE;   // proc_port owns the response from here
				default: state <= C_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == C_LOOK) begin
			way_q      <= hit ? hit_way : victim_way;
			line_q     <= (proc.write && (hit || !victim_dirty)) ? proc.line_in : rd_line;
			mem_addr_q <= fill_addr;
			if (!hit && victim_dirty)
				mem_addr_q.addr.tag <= victim_tag;   // write back to the victim's address
		end
		if (state == C_WB && mem.done) begin
			mem_addr_q <= fill_addr;
			if (proc.write)
				line_q <= proc.line_in;
		end
		if (state == C_FILL && mem.done)
			line_q <= mem.line_in;
	end

	assign proc.start    = (state == C_RESP);
	assign proc.line_out = line_q;

	assign mem.start    = mem_start_q;
	assign mem.write    = mem_write_q;
	assign mem.addr     = mem_addr_q;
	assign mem.rtag     = proc.rtag;
	assign mem.line_out = line_q;

	assign index     = proc.addr.addr.index;
	assign look_tag  = proc.addr.addr.tag;
	assign touch_en  = (state == C_LOOK) && hit && !proc.write;
	assign upd_en    = (state == C_UPD);
	assign upd_way   = way_q;
	assign upd_dirty = proc.write;   // writes install dirty, fills clean
	assign upd_line  = line_q;

	// one request in flight
	a_req_when_idle: assert property (@(posedge clk) disable iff (reset)
		proc.done |-> state == C_IDLE);

	a_mem_done_expected: assert property (@(posedge clk) disable iff (reset)
		mem.done |-> state inside {C_WB, C_FILL});

endmodule

// ==== hdl/cache_store.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_store import cache_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic [`INDEX_BITS-1:0]  index,
	input  line_tag_t               look_tag,
	output logic                    hit,
	output logic [WAY_BITS-1:0]     hit_way,
	output logic [WAY_BITS-1:0]     victim_way,
	output logic                    victim_dirty,
	output line_tag_t               victim_tag,
	output line_t                   rd_line,
	input  logic                    upd_en,
	input  logic [WAY_BITS-1:0]     upd_way,
	input  logic                    upd_dirty,
	input  line_t                   upd_line,
	input  logic                    touch_en
);

	localparam logic [`NUM_WAYS-1:0] WAY_ONE = 1;

	line_t                 data_mem    [`NUM_SETS][`NUM_WAYS];
	line_tag_t             tag_mem     [`NUM_SETS][`NUM_WAYS];
	logic [`NUM_WAYS-1:0]  valid_bits  [`NUM_SETS];
	logic [`NUM_WAYS-1:0]  dirty_bits  [`NUM_SETS];
	logic [`NUM_WAYS-1:0]  recent_bits [`NUM_SETS];   // one hot, last way touched
	logic [`NUM_WAYS-1:0]  hit_vec;
	logic [WAY_BITS-1:0]   rd_way;

	always_comb begin
		for (int w = 0; w < `NUM_WAYS; w++)
			hit_vec[w] = valid_bits[index][w] && (tag_mem[index][w] == look_tag);
	end

	assign hit = |hit_vec;

	// encode the hitting way
	always_comb begin
		hit_way = '0;
		for (int w = `NUM_WAYS - 1; w >= 0; w--)
			if (hit_vec[w]) hit_way = WAY_BITS'(w);
	end

	// first invalid way, else the one not touched last
	always_comb begin
		logic found;
		found      = 1'b0;
		victim_way = '0;
		for (int w = 0; w < `NUM_WAYS; w++) begin
			if (!found && !valid_bits[index][w]) begin
				victim_way = WAY_BITS'(w);
				found      = 1'b1;
			end
		end
		for (int w = 0; w < `NUM_WAYS; w++) begin
			if (!found && !recent_bits[index][w]) begin
				victim_way = WAY_BITS'(w);
				found      = 1'b1;
			end
		end
	end

	assign victim_dirty = valid_bits[index][victim_way] && dirty_bits[index][victim_way];
	assign victim_tag   = tag_mem[index][victim_way];
	assign rd_way       = hit ? hit_way : victim_way;   // victim line feeds write-back
	assign rd_line      = data_mem[index][rd_way];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < `NUM_SETS; s++) begin
				valid_bits[s]  <= '0;
				dirty_bits[s]  <= '0;
				recent_bits[s] <= '0;
			end
		end else if (upd_en) begin
			valid_bits[index][upd_way] <= 1'b1;
			dirty_bits[index][upd_way] <= upd_dirty;
			recent_bits[index]         <= WAY_ONE << upd_way;
		end else if (touch_en) begin
			recent_bits[index] <= WAY_ONE << hit_way;   // read hit
		end
	end

	always_ff @(posedge clk) begin
		if (upd_en) begin
			data_mem[index][upd_way] <= upd_line;
			tag_mem[index][upd_way]  <= look_tag;
		end
	end

	a_single_hit: assert property (@(posedge clk) disable iff (reset)
		$onehot0(hit_vec));

endmodule

// ==== hdl/mem_port.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module mem_port import cache_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       m_bus_reqack,
	input  logic                       m_bus_respcyc,
	input  logic [`BUS_DATA_WIDTH-1:0] m_bus_resp,
	input  bus_tag_t                   m_bus_resptag,
	output logic                       m_bus_reqcyc,
	output logic [`BUS_DATA_WIDTH-1:0] m_bus_req,
	output bus_tag_t                   m_bus_reqtag,
	output logic                       m_bus_respack,
	line_xfer_if.port                  xfer
);

	typedef enum logic [2:0] {
		M_IDLE, M_REQ, M_FILL, M_WDATA, M_WGAP, M_DONE
	} mstate_t;

	mstate_t              state;
	logic [BEAT_BITS-1:0] beat;
	line_t                fill_q;     // fill beats land here in arrival order
	bus_tag_t             req_tag;
	logic                 last_beat;

	assign last_beat = (beat == BEAT_BITS'(`LINE_BEATS - 1));

	// the write flag in the tag follows the transfer direction
	always_comb begin
		req_tag = xfer.rtag;
		req_tag[`SYSBUS_WRITE_BIT] = xfer.write ? `SYSBUS_WRITE : ~`SYSBUS_WRITE;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= M_IDLE;
			beat  <= '0;
		end else begin
			case (state)
				M_IDLE: begin
					if (xfer.start) begin
						beat  <= '0;
						state <= M_REQ;
					end
				end
				M_REQ: if (m_bus_reqack) state <= xfer.write ? M_WGAP : M_FILL;
				M_FILL: begin
					if (m_bus_respcyc) begin
						beat <= beat + 1'b1;
						if (last_beat)
							state <= M_DONE;
					end
				end
				M_WDATA: begin
					if (m_bus_reqack) begin
						beat  <= beat + 1'b1;
						state <= last_beat ? M_DONE : M_WGAP;
					end
				end
				M_WGAP: state <= M_WDATA;   // reqcyc low between words
				M_DONE: state <= M_IDLE;
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == M_FILL && m_bus_respcyc)
			fill_q[beat*`BUS_DATA_WIDTH +: `BUS_DATA_WIDTH] <= m_bus_resp;
	end

	assign m_bus_reqcyc  = (state == M_REQ) || (state == M_WDATA);
	assign m_bus_req     = (state == M_WDATA) ?
		xfer.line_out[beat*`BUS_DATA_WIDTH +: `BUS_DATA_WIDTH] : xfer.addr.data;
	assign m_bus_reqtag  = req_tag;
	assign m_bus_respack = (state == M_FILL) && m_bus_respcyc;   // take every beat offered

	assign xfer.done    = (state == M_DONE);
	assign xfer.line_in = fill_q;

	// request word and strobe stay put until memory acks
	a_req_held: assert property (@(posedge clk) disable iff (reset)
		m_bus_reqcyc && !m_bus_reqack |=> m_bus_reqcyc && $stable(m_bus_req));

	a_fill_tag_echo: assert property (@(posedge clk) disable iff (reset)
		m_bus_respack |-> m_bus_resptag == req_tag);

endmodule

// ==== hdl/proc_port.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module proc_port import cache_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       p_bus_reqcyc,
	input  bus_word_u                  p_bus_req,
	input  bus_tag_t                   p_bus_reqtag,
	input  logic                       p_bus_respack,
	output logic                       p_bus_reqack,
	output logic                       p_bus_respcyc,
	output logic [`BUS_DATA_WIDTH-1:0] p_bus_resp,
	output bus_tag_t                   p_bus_resptag,
	line_xfer_if.port                  xfer
);

	typedef enum logic [2:0] {
		P_IDLE, P_ACK, P_DATA, P_DACK, P_DONE, P_WAIT, P_RESP, P_GAP
	} pstate_t;

	pstate_t               state;
	logic [BEAT_BITS-1:0]  beat;      // write beat in, or response beat out
	bus_word_u             addr_q;
	bus_tag_t              tag_q;
	line_t                 wline_q;   // gathered write line
	logic                  is_write;
	logic                  last_beat;

	assign is_write  = (tag_q[`SYSBUS_WRITE_BIT] == `SYSBUS_WRITE);
	assign last_beat = (beat == BEAT_BITS'(`LINE_BEATS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= P_IDLE;
			beat  <= '0;
		end else begin
			case (state)
				P_IDLE: if (p_bus_reqcyc) state <= P_ACK;
				P_ACK: begin
					beat  <= '0;
					state <= is_write ? P_DATA : P_DONE;
				end
				P_DATA: if (p_bus_reqcyc) state <= P_DACK;   // next data word
				P_DACK: begin
					beat  <= beat + 1'b1;
					state <= last_beat ? P_DONE : P_DATA;
				end
				P_DONE: state <= P_WAIT;   // request handed to ctrl
				P_WAIT: begin
					// a write gets no data back, start just releases the port
					if (xfer.start) begin
						beat  <= '0;
						state <= is_write ? P_IDLE : P_RESP;
					end
				end
				P_RESP: if (p_bus_respack) state <= P_GAP;
				P_GAP: begin
					beat  <= beat + 1'b1;
					state <= last_beat ? P_IDLE : P_RESP;
				end
				default: state <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == P_IDLE && p_bus_reqcyc) begin
			addr_q <= p_bus_req;
			tag_q  <= p_bus_reqtag;
		end
		if (state == P_DATA && p_bus_reqcyc)
			wline_q[beat*`BUS_DATA_WIDTH +: `BUS_DATA_WIDTH] <= p_bus_req.data;
	end

	assign p_bus_reqack  = (state == P_ACK) || (state == P_DACK);
	assign p_bus_respcyc = (state == P_RESP);
	assign p_bus_resp    = xfer.line_out[beat*`BUS_DATA_WIDTH +: `BUS_DATA_WIDTH];
	assign p_bus_resptag = tag_q;   // echo the request tag

	assign xfer.done    = (state == P_DONE);
	assign xfer.write   = is_write;
	assign xfer.addr    = addr_q;
	assign xfer.rtag    = tag_q;
	assign xfer.line_in = wline_q;

	a_ack_needs_cyc: assert property (@(posedge clk) disable iff (reset)
		p_bus_reqack |-> p_bus_reqcyc);

	// ctrl only orders a response once the request has been handed over
	a_start_when_waiting: assert property (@(posedge clk) disable iff (reset)
		xfer.start |-> state == P_WAIT);

endmodule

// ==== hdl/line_xfer_if.sv ====
`timescale 1ns/1ps

// one whole-line transfer between the controller and a bus port
interface line_xfer_if import cache_pkg::*;;

	logic  start;      // from ctl, one cycle, only while the port is idle
	logic  done;       // from port, one cycle once the line has moved
	line_t line_out;   // ctl to port
	line_t line_in;    // port to ctl, valid from done until the next start

	// request fields come from the side that originates the transfer
	// proc_port on the processor side, the controller on the memory side
	wire logic      write;
	wire bus_word_u addr;
	wire bus_tag_t  rtag;

	modport ctl (output start, line_out, input done, line_in,
		inout write, addr, rtag);

	modport port (input start, line_out, output done, line_in,
		inout write, addr, rtag);

endinterface

// ==== hdl/cache_pkg.sv ====
`include "cache_config.svh"

package cache_pkg;

	// derived widths
	localparam int LINE_BITS = `BUS_DATA_WIDTH * `LINE_BEATS;
	localparam int LTAG_BITS = `BUS_DATA_WIDTH - `INDEX_BITS - `OFFSET_BITS;
	localparam int BEAT_BITS = $clog2(`LINE_BEATS);   // beat counter width
	localparam int WAY_BITS  = $clog2(`NUM_WAYS);

	typedef logic [`BUS_TAG_WIDTH-1:0] bus_tag_t;
	typedef logic [LTAG_BITS-1:0] line_tag_t;   // stored tag, upper address bits

	// whole line, beat k sits at bits 64k and up
	typedef logic [LINE_BITS-1:0] line_t;

	// byte address split into cache fields
	typedef struct packed {
		line_tag_t                tag;
		logic [`INDEX_BITS-1:0]  index;
		logic [`OFFSET_BITS-1:0] offset;
	} addr_fields_t;

	// one bus word, an address in the request beat, raw data in data beats
	typedef union packed {
		addr_fields_t               addr;
		logic [`BUS_DATA_WIDTH-1:0] data;
	} bus_word_u;

endpackage

// ==== include/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// system bus geometry, same on processor and memory side
`define BUS_DATA_WIDTH   64
`define BUS_TAG_WIDTH    13
`define SYSBUS_WRITE_BIT 12    // tag bit that flags a write request
`define SYSBUS_WRITE     1'b1  // value of that bit for a write

// a 64 byte line moves as eight bus words
`define LINE_BEATS 8

// two-way set associative, 32 lines in all
`define NUM_SETS    16
`define NUM_WAYS    2
`define OFFSET_BITS 6          // byte offset inside a line
`define INDEX_BITS  4          // log2 of NUM_SETS

`endif
